//--- rtl/mips_isa_pkg.sv
package mips_isa_pkg;

	localparam int word_w = 32;
	localparam int reg_addr_w = 5;

	// instruction field widths
	localparam int opcode_w = 6;
	localparam int shamt_w = 5;
	localparam int funct_w = 6;
	localparam int imm_w = 16;

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	localparam logic [opcode_w-1:0] op_special = 6'h00, op_andi = 6'h0c, op_ori = 6'h0d,
		op_xori = 6'h0e, op_lui = 6'h0f;

	localparam logic [funct_w-1:0] fn_and = 6'h24, fn_or = 6'h25, fn_xor = 6'h26,
		fn_nor = 6'h27, fn_sll = 6'h00, fn_srl = 6'h02, fn_sra = 6'h03, fn_sllv = 6'h04,
		fn_srlv = 6'h06, fn_srav = 6'h07, fn_div = 6'h1a, fn_divu = 6'h1b, fn_mfhi = 6'h10,
		fn_mflo = 6'h12;

	// register format
	typedef struct packed {
		logic [opcode_w-1:0] opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [shamt_w-1:0] shamt;
		logic [funct_w-1:0] funct;
	} instr_r_t;

	// immediate format
	typedef struct packed {
		logic [opcode_w-1:0] opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		logic [imm_w-1:0] imm;
	} instr_i_t;

	// same word, view picked by opcode
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

//--- rtl/mips_exec_pkg.sv
package mips_exec_pkg;

	localparam int div_cnt_w = 6;
	// restoring steps per division
	localparam logic [div_cnt_w-1:0] div_steps = 6'd32;

	// where the written value comes from
	typedef enum logic [1:0] {
		kind_gpr = 2'd0,
		kind_hi = 2'd1,
		kind_lo = 2'd2
	} res_kind_t;

	typedef struct packed {
		mips_isa_pkg::instr_u instr;
		mips_isa_pkg::word_t rs_val;
		mips_isa_pkg::word_t rt_val;
	} issue_t;

	typedef struct packed {
		logic valid;
		res_kind_t kind;
		mips_isa_pkg::reg_addr_t wd;
		mips_isa_pkg::word_t wdata;
	} alu_res_t;

	typedef struct packed {
		logic start;
		logic is_signed;
		mips_isa_pkg::word_t dividend;
		mips_isa_pkg::word_t divisor;
	} div_req_t;

	typedef struct packed {
		logic done;
		mips_isa_pkg::word_t quot;
		mips_isa_pkg::word_t rem;
	} div_res_t;

endpackage

//--- rtl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
	input  logic                     clk,
	input  logic                     rst_i,
	input  mips_exec_pkg::issue_t    issue_i,
	input  logic                     issue_valid_i,
	output mips_exec_pkg::alu_res_t  alu_res_o,
	output mips_exec_pkg::div_req_t  div_req_o
);

	mips_isa_pkg::instr_u instr;
	mips_isa_pkg::word_t rs_val;
	mips_isa_pkg::word_t rt_val;
	mips_isa_pkg::word_t imm_zx;
	logic [mips_isa_pkg::shamt_w-1:0] rs_amt;
	logic is_div;
	mips_exec_pkg::alu_res_t res_d;
	mips_exec_pkg::alu_res_t res_q;

	assign instr = issue_i.instr;
	assign rs_val = issue_i.rs_val;
	assign rt_val = issue_i.rt_val;
	assign imm_zx = mips_isa_pkg::word_t'(instr.i.imm);
	// variable shifts take the low bits of rs
	assign rs_amt = rs_val[mips_isa_pkg::shamt_w-1:0];

	always_comb begin
		res_d = '0;
		res_d.valid = 1'b1;
		res_d.kind = mips_exec_pkg::kind_gpr;
		is_div = 1'b0;
		// rd for special, rt for immediates
		res_d.wd = (instr.r.opcode == mips_isa_pkg::op_special) ? instr.r.rd : instr.i.rt;
		case (instr.r.opcode)
			mips_isa_pkg::op_special: begin
				case (instr.r.funct)
					mips_isa_pkg::fn_and:  res_d.wdata = rs_val & rt_val;
					mips_isa_pkg::fn_or:   res_d.wdata = rs_val | rt_val;
					mips_isa_pkg::fn_xor:  res_d.wdata = rs_val ^ rt_val;
					mips_isa_pkg::fn_nor:  res_d.wdata = ~(rs_val | rt_val);
					mips_isa_pkg::fn_sll:  res_d.wdata = rt_val << instr.r.shamt;
					mips_isa_pkg::fn_srl:  res_d.wdata = rt_val >> instr.r.shamt;
					mips_isa_pkg::fn_sra:  res_d.wdata = $signed(rt_val) >>> instr.r.shamt;
					mips_isa_pkg::fn_sllv: res_d.wdata = rt_val << rs_amt;
					mips_isa_pkg::fn_srlv: res_d.wdata = rt_val >> rs_amt;
					mips_isa_pkg::fn_srav: res_d.wdata = $signed(rt_val) >>> rs_amt;
					mips_isa_pkg::fn_mfhi: res_d.kind = mips_exec_pkg::kind_hi;
					mips_isa_pkg::fn_mflo: res_d.kind = mips_exec_pkg::kind_lo;
					mips_isa_pkg::fn_div, mips_isa_pkg::fn_divu: begin
						// handed to the divider, no gpr result
						res_d.valid = 1'b0;
						is_div = 1'b1;
					end
					default: res_d.valid = 1'b0;
				endcase
			end
			mips_isa_pkg::op_andi: res_d.wdata = rs_val & imm_zx;
			mips_isa_pkg::op_ori:  res_d.wdata = rs_val | imm_zx;
			mips_isa_pkg::op_xori: res_d.wdata = rs_val ^ imm_zx;
			mips_isa_pkg::op_lui:
				res_d.wdata = {instr.i.imm, {(mips_isa_pkg::word_w - mips_isa_pkg::imm_w){1'b0}}};
			default: res_d.valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			res_q.valid <= 1'b0;
		end else begin
			res_q.valid <= issue_valid_i & res_d.valid;
		end
		if (issue_valid_i & res_d.valid) begin
			res_q.kind <= res_d.kind;
			res_q.wd <= res_d.wd;
			// hi/lo reads pick their value later
			if (res_d.kind == mips_exec_pkg::kind_gpr) begin
				res_q.wdata <= res_d.wdata;
			end
		end
	end

	assign alu_res_o = res_q;

	assign div_req_o = '{
		start: issue_valid_i & is_div,
		is_signed: (instr.r.funct == mips_isa_pkg::fn_div),
		dividend: rs_val,
		divisor: rt_val
	};

endmodule

//--- rtl/div_unit.sv
`timescale 1ns/1ps

module div_unit (
	input  logic                     clk,
	input  logic                     rst_i,
	input  mips_exec_pkg::div_req_t  div_req_i,
	output mips_exec_pkg::div_res_t  div_res_o
);

	logic running_q;
	logic [mips_exec_pkg::div_cnt_w-1:0] cnt_q;

	// divisor magnitude
	mips_isa_pkg::word_t dvs_q;
	// dividend bits shift out at the top, quotient bits shift in below
	mips_isa_pkg::word_t quo_q;
	mips_isa_pkg::word_t rem_q;
	logic quot_neg_q;
	logic rem_neg_q;

	logic dvd_neg;
	logic dvs_neg;
	mips_isa_pkg::word_t dvd_mag;
	mips_isa_pkg::word_t dvs_mag;
	logic [mips_isa_pkg::word_w:0] rem_sh;
	logic [mips_isa_pkg::word_w:0] diff;
	logic q_bit;
	logic done;

	assign dvd_neg = div_req_i.is_signed & div_req_i.dividend[mips_isa_pkg::word_w-1];
	assign dvs_neg = div_req_i.is_signed & div_req_i.divisor[mips_isa_pkg::word_w-1];
	assign dvd_mag = dvd_neg ? -div_req_i.dividend : div_req_i.dividend;
	assign dvs_mag = dvs_neg ? -div_req_i.divisor : div_req_i.divisor;

	// one restoring step
	assign rem_sh = {rem_q, quo_q[mips_isa_pkg::word_w-1]};
	assign diff = rem_sh - {1'b0, dvs_q};
	assign q_bit = ~diff[mips_isa_pkg::word_w];

	assign done = running_q & (cnt_q == mips_exec_pkg::div_steps);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			running_q <= 1'b0;
			cnt_q <= '0;
		end else if (div_req_i.start) begin
			running_q <= 1'b1;
			cnt_q <= '0;
		end else if (done) begin
			running_q <= 1'b0;
		end else if (running_q) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (div_req_i.start) begin
			dvs_q <= dvs_mag;
			quo_q <= dvd_mag;
			rem_q <= '0;
			// a zero divisor keeps the all-ones quotient as it comes out
			quot_neg_q <= (dvd_neg ^ dvs_neg) & (|div_req_i.divisor);
			rem_neg_q <= dvd_neg;
		end else if (running_q & ~done) begin
			rem_q <= q_bit ? diff[mips_isa_pkg::word_w-1:0] : rem_sh[mips_isa_pkg::word_w-1:0];
			quo_q <= {quo_q[mips_isa_pkg::word_w-2:0], q_bit};
		end
	end

	// remainder follows the dividend sign
	assign div_res_o = '{
		done: done,
		quot: quot_neg_q ? -quo_q : quo_q,
		rem: rem_neg_q ? -rem_q : rem_q
	};

endmodule

//--- rtl/result_merge.sv
`timescale 1ns/1ps

module result_merge (
	input  logic                       clk,
	input  logic                       rst_i,
	input  mips_exec_pkg::alu_res_t    alu_res_i,
	input  logic                       div_start_i,
	input  mips_exec_pkg::div_res_t    div_res_i,
	output logic                       busy_o,
	output logic                       result_valid_o,
	output mips_isa_pkg::reg_addr_t    wd_o,
	output mips_isa_pkg::word_t        wdata_o
);

	mips_isa_pkg::word_t hi_q;
	mips_isa_pkg::word_t lo_q;

	// hi gets the remainder, lo the quotient
	always_ff @(posedge clk) begin
		if (rst_i) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (div_res_i.done) begin
			hi_q <= div_res_i.rem;
			lo_q <= div_res_i.quot;
		end
	end

	// high from the cycle after the start until done
	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy_o <= 1'b0;
		end else if (div_start_i) begin
			busy_o <= 1'b1;
		end else if (div_res_i.done) begin
			busy_o <= 1'b0;
		end
	end

	assign result_valid_o = alu_res_i.valid;
	assign wd_o = alu_res_i.wd;

	// mfhi/mflo read the pair in the result cycle
	always_comb begin
		case (alu_res_i.kind)
			mips_exec_pkg::kind_hi: wdata_o = hi_q;
			mips_exec_pkg::kind_lo: wdata_o = lo_q;
			default: wdata_o = alu_res_i.wdata;
		endcase
	end

endmodule

//--- rtl/mips_ex.sv
`timescale 1ns/1ps

module mips_ex (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     issue_valid_i,
	input  mips_isa_pkg::word_t      instr_i,
	input  mips_isa_pkg::word_t      rs_val_i,
	input  mips_isa_pkg::word_t      rt_val_i,
	output logic                     busy_o,
	output logic                     result_valid_o,
	output mips_isa_pkg::reg_addr_t  wd_o,
	output mips_isa_pkg::word_t      wdata_o
);

	mips_exec_pkg::issue_t issue;
	mips_exec_pkg::alu_res_t alu_res;
	mips_exec_pkg::div_req_t div_req;
	mips_exec_pkg::div_res_t div_res;
	logic issue_acc;

	// issues offered while dividing are dropped
	assign issue_acc = issue_valid_i & ~busy_o;
	assign issue = '{instr: instr_i, rs_val: rs_val_i, rt_val: rt_val_i};

	alu_unit alu_unit0 (
		.clk(clk),
		.rst_i(rst_i),
		.issue_i(issue),
		.issue_valid_i(issue_acc),
		.alu_res_o(alu_res),
		.div_req_o(div_req)
	);

	div_unit div_unit0 (
		.clk(clk),
		.rst_i(rst_i),
		.div_req_i(div_req),
		.div_res_o(div_res)
	);

	result_merge result_merge0 (
		.clk(clk),
		.rst_i(rst_i),
		.alu_res_i(alu_res),
		.div_start_i(div_req.start),
		.div_res_i(div_res),
		.busy_o(busy_o),
		.result_valid_o(result_valid_o),
		.wd_o(wd_o),
		.wdata_o(wdata_o)
	);

endmodule

//--- verif/mips_ex_assert.sv
`timescale 1ns/1ps

module mips_ex_assert (
	input logic                 clk,
	input logic                 rst_i,
	input logic                 issue_valid_i,
	input mips_isa_pkg::word_t  instr_i,
	input logic                 busy_i,
	input logic                 result_valid_i
);

	logic [5:0] op;
	logic [5:0] fn;
	logic acc;
	logic is_div;
	logic is_alu;
	int fail_cnt;

	assign op = instr_i[31:26];
	assign fn = instr_i[5:0];
	assign acc = issue_valid_i & ~busy_i;
	assign is_div = (op == mips_isa_pkg::op_special) &&
		(fn == mips_isa_pkg::fn_div || fn == mips_isa_pkg::fn_divu);
	// known encodings that write a register
	assign is_alu = (op == mips_isa_pkg::op_special) ?
		(fn inside {mips_isa_pkg::fn_and, mips_isa_pkg::fn_or, mips_isa_pkg::fn_xor,
			mips_isa_pkg::fn_nor, mips_isa_pkg::fn_sll, mips_isa_pkg::fn_srl,
			mips_isa_pkg::fn_sra, mips_isa_pkg::fn_sllv, mips_isa_pkg::fn_srlv,
			mips_isa_pkg::fn_srav, mips_isa_pkg::fn_mfhi, mips_isa_pkg::fn_mflo}) :
		(op inside {mips_isa_pkg::op_andi, mips_isa_pkg::op_ori, mips_isa_pkg::op_xori,
			mips_isa_pkg::op_lui});

	busy_after_reset: assert property (@(posedge clk) rst_i |=> !busy_i)
		else begin
			fail_cnt++;
			$error("busy_o high in the cycle after a reset cycle");
		end

	result_follows: assert property (@(posedge clk) disable iff (rst_i)
		acc && is_alu |=> result_valid_i)
		else begin
			fail_cnt++;
			$error("no result one cycle after an accepted instruction");
		end

	no_stray_result: assert property (@(posedge clk) disable iff (rst_i)
		!(acc && is_alu) |=> !result_valid_i)
		else begin
			fail_cnt++;
			$error("result_valid_o without an accepted instruction");
		end

	// 32 steps plus the done cycle
	busy_length: assert property (@(posedge clk) disable iff (rst_i)
		acc && is_div |=> busy_i [*33] ##1 !busy_i)
		else begin
			fail_cnt++;
			$error("busy_o not high for exactly 33 cycles after a division");
		end

endmodule

//--- verif/tb_mips_ex.sv
`timescale 1ns/1ps

module tb_mips_ex;

	logic clk;
	logic rst_i;
	logic issue_valid_i;
	mips_isa_pkg::word_t instr_i;
	mips_isa_pkg::word_t rs_val_i;
	mips_isa_pkg::word_t rt_val_i;
	logic busy_o;
	logic result_valid_o;
	mips_isa_pkg::reg_addr_t wd_o;
	mips_isa_pkg::word_t wdata_o;

	logic [31:0] lfsr_q;
	// reference model state
	mips_isa_pkg::word_t m_hi;
	mips_isa_pkg::word_t m_lo;
	mips_isa_pkg::word_t div_hi;
	mips_isa_pkg::word_t div_lo;
	int div_left;
	logic pend_valid;
	mips_isa_pkg::reg_addr_t pend_wd;
	mips_isa_pkg::word_t pend_data;
	int checks;
	int errors;
	int tests;
	int checks0;
	int errors0;

	mips_ex dut (
		.clk(clk),
		.rst_i(rst_i),
		.issue_valid_i(issue_valid_i),
		.instr_i(instr_i),
		.rs_val_i(rs_val_i),
		.rt_val_i(rt_val_i),
		.busy_o(busy_o),
		.result_valid_o(result_valid_o),
		.wd_o(wd_o),
		.wdata_o(wdata_o)
	);

	bind mips_ex mips_ex_assert assert0 (
		.clk(clk),
		.rst_i(rst_i),
		.issue_valid_i(issue_valid_i),
		.instr_i(instr_i),
		.busy_i(busy_o),
		.result_valid_i(result_valid_o)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic mips_isa_pkg::word_t make_r(input logic [5:0] fn, input logic [4:0] sa);
		logic [31:0] r;
		r = rand_bits(15);
		return {mips_isa_pkg::op_special, r[14:0], sa, fn};
	endfunction

	function automatic mips_isa_pkg::word_t make_i(input logic [5:0] op, input logic [15:0] imm);
		logic [31:0] r;
		r = rand_bits(10);
		return {op, r[9:0], imm};
	endfunction

	function automatic mips_isa_pkg::word_t rand_logic();
		logic [31:0] r;
		mips_isa_pkg::word_t w;
		r = rand_bits(19);
		case (r[18:16])
			3'd0: w = make_r(mips_isa_pkg::fn_and, 5'd0);
			3'd1: w = make_r(mips_isa_pkg::fn_or, 5'd0);
			3'd2: w = make_r(mips_isa_pkg::fn_xor, 5'd0);
			3'd3: w = make_r(mips_isa_pkg::fn_nor, 5'd0);
			3'd4: w = make_i(mips_isa_pkg::op_andi, r[15:0]);
			3'd5: w = make_i(mips_isa_pkg::op_ori, r[15:0]);
			3'd6: w = make_i(mips_isa_pkg::op_xori, r[15:0]);
			default: w = make_i(mips_isa_pkg::op_lui, r[15:0]);
		endcase
		return w;
	endfunction

	task automatic mismatch(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	task automatic abort(input string msg);
		$display("timeout: %s", msg);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic model_accept(input mips_isa_pkg::word_t ins, input mips_isa_pkg::word_t rs,
		input mips_isa_pkg::word_t rt);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] sa;
		mips_isa_pkg::word_t imm;
		op = ins[31:26];
		fn = ins[5:0];
		sa = ins[10:6];
		imm = {16'h0000, ins[15:0]};
		pend_valid = 1'b1;
		pend_wd = (op == mips_isa_pkg::op_special) ? ins[15:11] : ins[20:16];
		pend_data = '0;
		if (op == mips_isa_pkg::op_special) begin
			case (fn)
				mips_isa_pkg::fn_and: pend_data = rs & rt;
				mips_isa_pkg::fn_or: pend_data = rs | rt;
				mips_isa_pkg::fn_xor: pend_data = rs ^ rt;
				mips_isa_pkg::fn_nor: pend_data = ~(rs | rt);
				mips_isa_pkg::fn_sll: pend_data = rt << sa;
				mips_isa_pkg::fn_srl: pend_data = rt >> sa;
				mips_isa_pkg::fn_sra: pend_data = $signed(rt) >>> sa;
				mips_isa_pkg::fn_sllv: pend_data = rt << rs[4:0];
				mips_isa_pkg::fn_srlv: pend_data = rt >> rs[4:0];
				mips_isa_pkg::fn_srav: pend_data = $signed(rt) >>> rs[4:0];
				mips_isa_pkg::fn_mfhi: pend_data = m_hi;
				mips_isa_pkg::fn_mflo: pend_data = m_lo;
				mips_isa_pkg::fn_div, mips_isa_pkg::fn_divu: begin
					pend_valid = 1'b0;
					div_left = 33;
					if (rt == '0) begin
						// zero divisor leaves the dividend in hi
						div_lo = '1;
						div_hi = rs;
					end else if (fn == mips_isa_pkg::fn_div && rs == 32'h8000_0000 && rt == '1) begin
						div_lo = 32'h8000_0000;
						div_hi = '0;
					end else if (fn == mips_isa_pkg::fn_div) begin
						div_lo = $signed(rs) / $signed(rt);
						div_hi = $signed(rs) % $signed(rt);
					end else begin
						div_lo = rs / rt;
						div_hi = rs % rt;
					end
				end
				default: pend_valid = 1'b0;
			endcase
		end else begin
			case (op)
				mips_isa_pkg::op_andi: pend_data = rs & imm;
				mips_isa_pkg::op_ori: pend_data = rs | imm;
				mips_isa_pkg::op_xori: pend_data = rs ^ imm;
				mips_isa_pkg::op_lui: pend_data = {ins[15:0], 16'h0000};
				default: pend_valid = 1'b0;
			endcase
		end
	endtask

	task automatic issue_cycle(input logic v, input mips_isa_pkg::word_t ins,
		input mips_isa_pkg::word_t rs, input mips_isa_pkg::word_t rt);
		logic exp_busy;
		@(posedge clk);
		issue_valid_i <= v;
		instr_i <= ins;
		rs_val_i <= rs;
		rt_val_i <= rt;
		@(negedge clk);
		// outputs show the edge that took the previous issue
		checks++;
		if (pend_valid) begin
			if (result_valid_o !== 1'b1 || wd_o !== pend_wd || wdata_o !== pend_data) begin
				mismatch($sformatf("result valid %b wd %0d data %h, expected wd %0d data %h",
					result_valid_o, wd_o, wdata_o, pend_wd, pend_data));
			end
		end else if (result_valid_o !== 1'b0) begin
			mismatch($sformatf("unexpected result, wd %0d data %h", wd_o, wdata_o));
		end
		exp_busy = (div_left != 0);
		if (div_left != 0) begin
			div_left--;
			// next accepted issue already sees the new pair
			if (div_left == 0) begin
				m_hi = div_hi;
				m_lo = div_lo;
			end
		end
		if (busy_o !== exp_busy) begin
			mismatch($sformatf("busy_o %b, expected %b", busy_o, exp_busy));
		end
		pend_valid = 1'b0;
		if (v && !exp_busy) begin
			model_accept(ins, rs, rt);
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		do begin
			issue_cycle(1'b0, '0, '0, '0);
			n++;
			if (n > 64) begin
				abort("divider still busy after 64 cycles");
			end
		end while (busy_o === 1'b1);
	endtask

	task automatic read_hilo();
		issue_cycle(1'b1, make_r(mips_isa_pkg::fn_mflo, 5'd0), '0, '0);
		issue_cycle(1'b1, make_r(mips_isa_pkg::fn_mfhi, 5'd0), '0, '0);
		issue_cycle(1'b0, '0, '0, '0);
	endtask

	task automatic begin_test();
		checks0 = checks;
		errors0 = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s: %0d checks, %0d errors", name, checks - checks0, errors - errors0);
	endtask

	initial begin
		int i;
		int n;
		mips_isa_pkg::word_t a;
		mips_isa_pkg::word_t b;
		mips_isa_pkg::word_t ins;
		logic [5:0] fn;
		logic [4:0] sa;
		lfsr_q = 32'hac5d;
		m_hi = '0;
		m_lo = '0;
		div_left = 0;
		pend_valid = 1'b0;
		checks = 0;
		errors = 0;
		tests = 0;
		rst_i = 1'b1;
		issue_valid_i = 1'b0;
		instr_i = '0;
		rs_val_i = '0;
		rt_val_i = '0;
		repeat (16) @(posedge clk);
		rst_i <= 1'b0;

		begin_test();
		read_hilo();
		end_test("reset hi/lo");

		begin_test();
		for (i = 0; i < 200; i++) begin
			ins = rand_logic();
			a = rand_bits(32);
			b = rand_bits(32);
			issue_cycle(1'b1, ins, a, b);
		end
		issue_cycle(1'b0, '0, '0, '0);
		end_test("logic and lui");

		begin_test();
		for (i = 0; i < 120; i++) begin
			a = rand_bits(32);
			b = rand_bits(32);
			sa = a[4:0];
			// every shift kind meets amounts 0 and 31, with and without a negative operand
			if ((i / 6) % 4 == 0) sa = 5'd0;
			if ((i / 6) % 4 == 1) sa = 5'd31;
			a[4:0] = sa;
			if ((i / 24) % 2 == 1) b[31] = 1'b1;
			case (i % 6)
				0: fn = mips_isa_pkg::fn_sll;
				1: fn = mips_isa_pkg::fn_srl;
				2: fn = mips_isa_pkg::fn_sra;
				3: fn = mips_isa_pkg::fn_sllv;
				4: fn = mips_isa_pkg::fn_srlv;
				default: fn = mips_isa_pkg::fn_srav;
			endcase
			issue_cycle(1'b1, make_r(fn, sa), a, b);
		end
		issue_cycle(1'b0, '0, '0, '0);
		end_test("shifts");

		begin_test();
		for (i = 0; i < 24; i++) begin
			a = rand_bits(32);
			b = rand_bits(32);
			fn = rand_bits(1) ? mips_isa_pkg::fn_div : mips_isa_pkg::fn_divu;
			if (i % 6 == 0) b = '0;
			if (i % 6 == 1) b = '1;
			if (i % 6 == 2) b = b >> 20;
			if (i % 12 == 1) begin
				a = 32'h8000_0000;
				fn = mips_isa_pkg::fn_div;
			end
			issue_cycle(1'b1, make_r(fn, 5'd0), a, b);
			wait_idle();
			read_hilo();
		end
		end_test("division");

		begin_test();
		for (i = 0; i < 4; i++) begin
			ins = rand_logic();
			a = rand_bits(32);
			b = rand_bits(32);
			issue_cycle(1'b1, ins, a, b);
			issue_cycle(1'b1, make_r(mips_isa_pkg::fn_divu, 5'd0), b, a >> 20);
			n = 0;
			do begin
				// divisions offered here must not restart the divider or touch hi/lo
				case (rand_bits(2))
					2'd0: ins = make_r(mips_isa_pkg::fn_mfhi, 5'd0);
					2'd1: ins = make_r(mips_isa_pkg::fn_div, 5'd0);
					default: ins = rand_logic();
				endcase
				a = rand_bits(32);
				issue_cycle(1'b1, ins, a, ~a);
				if (busy_o === 1'b1) n++;
				if (n > 40) begin
					abort("busy_o high for more than 40 cycles after DIVU");
				end
			end while (busy_o === 1'b1);
			checks++;
			if (n != 33) begin
				mismatch($sformatf("busy_o high for %0d cycles after DIVU, expected 33", n));
			end
			wait_idle();
		end
		read_hilo();
		end_test("back-pressure");

		begin_test();
		for (i = 0; i < 24; i++) begin
			a = rand_bits(32);
			// addi group, add/sub group, mult group
			if (i % 3 == 0) ins = make_i({4'b0010, a[1:0]}, a[31:16]);
			else if (i % 3 == 1) ins = make_r({4'b1000, a[1:0]}, a[10:6]);
			else ins = make_r({5'b01100, a[0]}, 5'd0);
			issue_cycle(1'b1, ins, a, ~a);
		end
		read_hilo();
		end_test("unknown encodings");

		errors += dut.assert0.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- mips_ex.f
rtl/mips_isa_pkg.sv
rtl/mips_exec_pkg.sv
rtl/alu_unit.sv
rtl/div_unit.sv
rtl/result_merge.sv
rtl/mips_ex.sv
verif/mips_ex_assert.sv
verif/tb_mips_ex.sv
